/* verilog/roadf_pkg.sv */
//==============================
// shared constants for the main-CPU glue
// memory map follows the 6809 board layout
// cen_div assumes a 24 MHz clk, power of two
//==============================

package roadf_pkg;

    // clock enable
    localparam int cen_div = 16;                  // 24 MHz / 16 = 1.5 MHz bus
    localparam int cen_w   = $clog2(cen_div);     // divider counter width

    // work RAM, 4 kB
    localparam int ram_aw = 12;

    // 8 kB blocks, addr[15:13]
    localparam logic [2:0] io_blk       = 3'd0;   // 0000-1FFF, obj RAM and I/O
    localparam logic [2:0] vid_blk      = 3'd1;   // 2000-3FFF, video RAM and work RAM
    localparam logic [2:0] rom_base_blk = 3'd2;   // ROM from 4000 up

    // 1 kB sub-blocks inside io_blk, addr[12:10]
    localparam logic [2:0] obj_sub = 3'd4;        // 1000-13FF
    localparam logic [2:0] io_sub  = 3'd5;        // 1400-17FF

    // I/O strobes inside io_sub, addr[9:7]
    localparam logic [2:0] intst_sel = 3'd0;      // object frame toggle
    localparam logic [2:0] iow_sel   = 3'd1;      // write latch
    localparam logic [2:0] snd_sel   = 3'd2;      // sound latch
    localparam logic [2:0] in5_sel   = 3'd4;      // DIP bank B
    localparam logic [2:0] ior_sel   = 3'd5;      // cabinet word

    // decoded target of one bus cycle
    typedef enum logic [3:0] {
        rgn_none,       // unmapped, reads FF
        rgn_rom,
        rgn_vram,
        rgn_ram,
        rgn_objram,
        rgn_intst,
        rgn_iow,
        rgn_snd,
        rgn_in5,
        rgn_ior
    } region_e;

    // addressable latch outputs, index is addr[2:0]
    typedef enum logic [2:0] {
        lat_flip     = 3'd0,  // screen flip
        lat_snd_irq  = 3'd1,  // sound CPU interrupt
        lat_end      = 3'd2,  // test output, not modelled
        lat_coin1    = 3'd3,  // coin counters, not modelled
        lat_coin2    = 3'd4,
        lat_sa       = 3'd5,
        lat_nc       = 3'd6,  // unconnected
        lat_irq_clrn = 3'd7   // low holds vblank IRQ clear
    } latch_e;

endpackage

/* verilog/roadf_cen.sv */
//==============================
// CPU clock enable, one clk high per cen_div
// first strobe cen_div cycles after rst drops
//==============================

`timescale 1ns/1ps

module roadf_cen (
    input  logic clk,
    input  logic rst,
    output logic cpu_cen
);
    import roadf_pkg::*;

    localparam logic [cen_w-1:0] cnt_last = cen_w'(cen_div - 1);

    logic [cen_w-1:0] cnt;   // position inside the bus period

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            cpu_cen <= 1'b0;
        end else begin
            // wrap at terminal count
            if (cnt == cnt_last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            cpu_cen <= (cnt == cnt_last);   // registered strobe
        end
    end

endmodule

/* verilog/roadf_irq_ff.sv */
//==============================
// edge-set interrupt flip-flop
// clr wins over a coincident edge
// irq_n is active low, 6809 style
//==============================

`timescale 1ns/1ps

module roadf_irq_ff (
    input  logic clk,
    input  logic rst,
    input  logic trigger,   // level, edge detected here
    input  logic clr,       // active high, holds flag clear
    output logic irq_n
);

    logic trig_l;    // trigger one clk ago
    logic pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            trig_l  <= 1'b0;
            pending <= 1'b0;
        end else begin
            trig_l <= trigger;
            if (clr) begin
                pending <= 1'b0;
            end else if (trigger && !trig_l) begin
                pending <= 1'b1;   // 0 to 1 transition
            end
        end
    end

    assign irq_n = ~pending;

endmodule

/* verilog/roadf_work_ram.sv */
//==============================
// single-port work RAM, 2**ram_aw bytes
// read data one clk after the address
// read during write returns old byte
//==============================

`timescale 1ns/1ps

module roadf_work_ram (
    input  logic                        clk,
    input  logic [roadf_pkg::ram_aw-1:0] addr,
    input  logic                        we,
    input  logic [7:0]                  din,
    output logic [7:0]                  dout
);
    import roadf_pkg::*;

    logic [7:0] mem [0:2**ram_aw-1];   // no init, contents random at power up

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // read port, always enabled
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

/* verilog/roadf_main.sv */
//==============================
// main CPU glue: decode, read mux, latch
// bus must be stable for a full cen_div period
// cpu_din valid two clk after the address
//==============================

`timescale 1ns/1ps

module roadf_main (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cen,
    // CPU bus
    input  logic [15:0] addr,
    input  logic        rnw,
    input  logic        vma,
    input  logic [7:0]  cpu_dout,
    output logic [7:0]  cpu_din,
    output logic        irq_n,
    // chip selects
    output logic        rom_cs,
    output logic        vram_cs,
    output logic        objram_cs,
    output logic        snd_data_cs,
    // latch and video
    output logic        obj_frame,
    output logic        snd_irq,
    output logic        flip,
    // external memories
    input  logic [7:0]  rom_data,
    input  logic [7:0]  vram_dout,
    input  logic [7:0]  obj_dout,
    // cabinet
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic [6:0]  joystick1,
    input  logic [6:0]  joystick2,
    input  logic        service,
    input  logic        lvbl,
    input  logic        dip_pause,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [2:0]  dipsw_c     // board jumpers
);
    import roadf_pkg::*;

    region_e    rgn;
    logic       ram_cs, intst_cs, iow_cs, in5_cs, ior_cs;
    logic       ram_we;
    logic [7:0] ram_dout;
    logic [7:0] cabinet;
    logic       intst_l;       // intst seen on previous cpu_cen
    logic       irq_clrn;
    logic       irq_trigger;

    // address decode, one target per cycle
    always_comb begin
        rgn = rgn_none;
        if (vma) begin
            if (addr[15:13] >= rom_base_blk) begin
                if (rnw) rgn = rgn_rom;     // ROM is read only
            end else if (addr[15:13] == vid_blk) begin
                rgn = addr[12] ? rgn_ram : rgn_vram;   // 3000 up is work RAM
            end else if (addr[15:13] == io_blk) begin
                if (addr[12:10] == obj_sub) begin
                    rgn = rgn_objram;
                end else if (addr[12:10] == io_sub) begin
                    case (addr[9:7])
                        intst_sel: rgn = rgn_intst;
                        iow_sel:   rgn = rgn_iow;
                        snd_sel:   rgn = rgn_snd;
                        in5_sel:   rgn = rgn_in5;
                        ior_sel:   rgn = rgn_ior;
                        default:   rgn = rgn_none;   // 6 and 7 open
                    endcase
                end
            end
        end
    end

    assign rom_cs      = (rgn == rgn_rom);
    assign vram_cs     = (rgn == rgn_vram);
    assign ram_cs      = (rgn == rgn_ram);
    assign objram_cs   = (rgn == rgn_objram);
    assign intst_cs    = (rgn == rgn_intst);
    assign iow_cs      = (rgn == rgn_iow);
    assign snd_data_cs = (rgn == rgn_snd);
    assign in5_cs      = (rgn == rgn_in5);
    assign ior_cs      = (rgn == rgn_ior);

    // work RAM written on the cpu_cen edge
    assign ram_we = ram_cs && !rnw && cpu_cen;

    roadf_work_ram u_ram (
        .clk  (clk),
        .addr (addr[ram_aw-1:0]),
        .we   (ram_we),
        .din  (cpu_dout),
        .dout (ram_dout)
    );

    // cabinet word, joystick bits swapped in pairs as on the PCB
    always_ff @(posedge clk) begin
        case (addr[1:0])
            2'd0: cabinet <= {dipsw_c, start_button, service, coin_input};
            2'd1: cabinet <= {1'b1, joystick1[6:4], joystick1[2], joystick1[3],
                              joystick1[0], joystick1[1]};
            2'd2: cabinet <= {1'b1, joystick2[6:4], joystick2[2], joystick2[3],
                              joystick2[0], joystick2[1]};
            default: cabinet <= dipsw_a;
        endcase
    end

    // registered read mux, unmapped reads FF
    always_ff @(posedge clk) begin
        cpu_din <= rom_cs    ? rom_data  :
                   vram_cs   ? vram_dout :
                   ram_cs    ? ram_dout  :
                   objram_cs ? obj_dout  :
                   ior_cs    ? cabinet   :
                   in5_cs    ? dipsw_b   : 8'hff;
    end

    // write latch and frame toggle, bus edge only
    always_ff @(posedge clk) begin
        if (rst) begin
            flip      <= 1'b0;
            snd_irq   <= 1'b0;
            irq_clrn  <= 1'b0;   // keeps IRQ off until software enables it
            obj_frame <= 1'b0;
            intst_l   <= 1'b0;
        end else if (cpu_cen) begin
            intst_l <= intst_cs;
            if (intst_cs && !intst_l) obj_frame <= ~obj_frame;   // once per access
            if (iow_cs && !rnw) begin
                case (latch_e'(addr[2:0]))
                    lat_flip:     flip     <= cpu_dout[0];
                    lat_snd_irq:  snd_irq  <= cpu_dout[0];
                    lat_irq_clrn: irq_clrn <= cpu_dout[0];
                    default: ;   // counters and test pins dropped
                endcase
            end
        end
    end

    // vblank interrupt, masked while paused
    assign irq_trigger = ~lvbl & dip_pause;

    roadf_irq_ff u_irq (
        .clk     (clk),
        .rst     (rst),
        .trigger (irq_trigger),
        .clr     (~irq_clrn),
        .irq_n   (irq_n)
    );

endmodule

/* verilog/roadf_board.sv */
//==============================
// board top: clock enable plus main glue
// CPU bus comes from outside, sampled on cpu_cen
// ROM, video and object RAM stay external
//==============================

`timescale 1ns/1ps

module roadf_board (
    input  logic        clk,         // 24 MHz
    input  logic        rst,
    output logic        cpu_cen,     // bus strobe for the master
    // CPU bus
    input  logic [15:0] addr,
    input  logic        rnw,
    input  logic        vma,
    input  logic [7:0]  cpu_dout,
    output logic [7:0]  cpu_din,
    output logic        irq_n,
    // chip selects
    output logic        rom_cs,
    output logic        vram_cs,
    output logic        objram_cs,
    output logic        snd_data_cs,
    // latch and video
    output logic        obj_frame,
    output logic        snd_irq,
    output logic        flip,
    // external data
    input  logic [7:0]  rom_data,
    input  logic [7:0]  vram_dout,
    input  logic [7:0]  obj_dout,
    // cabinet and DIPs
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic [6:0]  joystick1,
    input  logic [6:0]  joystick2,
    input  logic        service,
    input  logic        lvbl,
    input  logic        dip_pause,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [2:0]  dipsw_c
);

    roadf_cen u_cen (
        .clk     (clk),
        .rst     (rst),
        .cpu_cen (cpu_cen)
    );

    roadf_main u_main (
        .clk          (clk),
        .rst          (rst),
        .cpu_cen      (cpu_cen),
        .addr         (addr),
        .rnw          (rnw),
        .vma          (vma),
        .cpu_dout     (cpu_dout),
        .cpu_din      (cpu_din),
        .irq_n        (irq_n),
        .rom_cs       (rom_cs),
        .vram_cs      (vram_cs),
        .objram_cs    (objram_cs),
        .snd_data_cs  (snd_data_cs),
        .obj_frame    (obj_frame),
        .snd_irq      (snd_irq),
        .flip         (flip),
        .rom_data     (rom_data),
        .vram_dout    (vram_dout),
        .obj_dout     (obj_dout),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .lvbl         (lvbl),
        .dip_pause    (dip_pause),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c)
    );

endmodule

/* bench/roadf_board_assertions.sv */
//==============================
// concurrent checks bound into roadf_main
// decode checks idle while rst is high
//==============================

`timescale 1ns/1ps

module roadf_board_assertions (
    input logic clk,
    input logic rst,
    input logic vma,
    input logic rom_cs, vram_cs, ram_cs, objram_cs, intst_cs,
    input logic iow_cs, snd_data_cs, in5_cs, ior_cs,
    input logic flip,
    input logic snd_irq,
    input logic irq_n,
    input logic irq_clrn
);

    logic [8:0] cs_all;   // every decoded select

    assign cs_all = {rom_cs, vram_cs, ram_cs, objram_cs, intst_cs,
                     iow_cs, snd_data_cs, in5_cs, ior_cs};

    cs_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(cs_all))
        else $error("more than one chip select active: %b", cs_all);

    cs_need_vma: assert property (@(posedge clk) disable iff (rst) !vma |-> cs_all == '0)
        else $error("chip select active with vma low: %b", cs_all);

    reset_clear: assert property (@(posedge clk) rst |=> (!flip && !snd_irq))
        else $error("flip or snd_irq set right after reset");

    // clear wins one clk after irq_clrn drops
    irq_masked: assert property (@(posedge clk) disable iff (rst) !irq_clrn |=> irq_n)
        else $error("irq_n low while irq_clrn low");

endmodule

bind roadf_main roadf_board_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .vma         (vma),
    .rom_cs      (rom_cs),
    .vram_cs     (vram_cs),
    .ram_cs      (ram_cs),
    .objram_cs   (objram_cs),
    .intst_cs    (intst_cs),
    .iow_cs      (iow_cs),
    .snd_data_cs (snd_data_cs),
    .in5_cs      (in5_cs),
    .ior_cs      (ior_cs),
    .flip        (flip),
    .snd_irq     (snd_irq),
    .irq_n       (irq_n),
    .irq_clrn    (irq_clrn)
);

/* bench/roadf_board_tb.sv */
//==============================
// testbench for roadf_board, acts as the CPU bus master
// bus changes only after a cpu_cen edge, held one period
// watchdog sized from the bus cycles of all tests
//==============================

`timescale 1ns/1ps

module roadf_board_tb;
    import roadf_pkg::*;

    localparam int clk_half = 20;      // 40 ns period
    localparam int n_decode = 300;
    localparam int n_mux    = 200;
    localparam int n_ram    = 64;
    localparam int n_latch  = 40;
    localparam int n_irq    = 16;
    localparam int n_bus    = n_decode + n_mux + 2 * n_ram + n_latch + n_irq + 4;
    localparam int timeout_ns = n_bus * cen_div * 2 * clk_half * 2;

    // testbench view of the decoded target
    typedef enum int {
        r_none, r_rom, r_vram, r_ram, r_obj, r_intst, r_iow, r_snd, r_in5, r_ior
    } tb_region_t;

    logic        clk, rst, cpu_cen;
    logic [15:0] addr;
    logic        rnw, vma, irq_n, service, lvbl, dip_pause;
    logic [7:0]  cpu_dout, cpu_din, rom_data, vram_dout, obj_dout;
    logic        rom_cs, vram_cs, objram_cs, snd_data_cs, obj_frame, snd_irq, flip;
    logic [1:0]  start_button, coin_input;
    logic [6:0]  joystick1, joystick2;
    logic [7:0]  dipsw_a, dipsw_b;
    logic [2:0]  dipsw_c;

    integer      seed = 41062;
    logic [7:0]  shadow [0:4095];      // work RAM model
    logic [15:0] ram_addr_q [$];
    logic        m_flip, m_snd, m_frame, m_intst;   // latch and toggle model
    bit          latch_checks;
    int          n_checks, n_errors;
    string       chk_name_q [$];       // pending compares
    logic [7:0]  chk_want_q [$];
    logic [7:0]  chk_got_q [$];
    event        chk_ev;

    roadf_board u_roadf_board (.*);

    initial begin : clock
        clk = 1'b0;
        forever #(clk_half) clk = ~clk;
    end

    function automatic tb_region_t ref_region(input logic [15:0] a, input logic r,
                                              input logic v);
        if (!v) return r_none;
        if (a[15:13] >= rom_base_blk) return r ? r_rom : r_none;   // ROM read only
        if (a >= 16'h3000) return r_ram;
        if (a >= 16'h2000) return r_vram;
        if (a[12:10] == 3'd4) return r_obj;     // 1000-13FF
        if (a[12:10] != 3'd5) return r_none;    // outside 1400-17FF
        case (a[9:7])
            3'd0: return r_intst;
            3'd1: return r_iow;
            3'd2: return r_snd;
            3'd4: return r_in5;
            3'd5: return r_ior;
            default: return r_none;
        endcase
    endfunction

    function automatic logic [7:0] ref_cabinet(input logic [1:0] sel);
        logic [6:0] j;
        j = (sel == 2'd1) ? joystick1 : joystick2;
        case (sel)
            2'd0: return {dipsw_c, start_button, service, coin_input};
            2'd3: return dipsw_a;
            default: return {1'b1, j[6], j[5], j[4], j[2], j[3], j[0], j[1]};   // pair swap
        endcase
    endfunction

    function automatic logic [7:0] ref_din(input logic [15:0] a);
        case (ref_region(a, 1'b1, 1'b1))
            r_rom:   return rom_data;
            r_vram:  return vram_dout;
            r_ram:   return shadow[a[11:0]];
            r_obj:   return obj_dout;
            r_ior:   return ref_cabinet(a[1:0]);
            r_in5:   return dipsw_b;
            default: return 8'hff;           // open bus and write-only strobes
        endcase
    endfunction

    task automatic expect_val(input string name, input logic [7:0] want,
                              input logic [7:0] got);
        chk_name_q.push_back(name);
        chk_want_q.push_back(want);
        chk_got_q.push_back(got);
        -> chk_ev;
    endtask

    // compare process, drains every queued check
    initial begin : compare
        string      nm;
        logic [7:0] want;
        logic [7:0] got;
        forever begin
            @(chk_ev);
            while (chk_name_q.size() > 0) begin
                nm   = chk_name_q.pop_front();
                want = chk_want_q.pop_front();
                got  = chk_got_q.pop_front();
                n_checks++;
                if (got !== want) begin
                    $display("Error %s expected %h got %h at %0t", nm, want, got, $time);
                    n_errors++;
                end
            end
        end
    end

    // wait for a strobe, drive after its edge, sample at the next strobe
    task automatic bus_cycle(input logic [15:0] a, input logic r, input logic v,
                             input logic [7:0] d, output logic [7:0] q);
        tb_region_t rg;
        int         cen_gap;                 // clk periods between two strobes
        while (cpu_cen !== 1'b1) @(negedge clk);
        @(negedge clk);                      // cen edge passed
        cen_gap  = 1;
        addr     = a;
        rnw      = r;
        vma      = v;
        cpu_dout = d;
        while (cpu_cen !== 1'b1) begin
            @(negedge clk);
            cen_gap++;
        end
        q = cpu_din;                         // stable until the cen edge
        expect_val("cpu_cen", 8'(cen_div), 8'(cen_gap));   // one strobe per bus period
        if (latch_checks) begin
            expect_val("flip", {7'd0, m_flip}, {7'd0, flip});
            expect_val("snd_irq", {7'd0, m_snd}, {7'd0, snd_irq});
            expect_val("obj_frame", {7'd0, m_frame}, {7'd0, obj_frame});
        end
        // effect of the cen edge that closes this cycle
        rg = ref_region(a, r, v);
        if (rg == r_intst && !m_intst) m_frame = !m_frame;   // first cycle of access
        m_intst = (rg == r_intst);
        if (rg == r_ram && !r) shadow[a[11:0]] = d;
        if (rg == r_iow && !r && a[2:0] == 3'd0) m_flip = d[0];
        if (rg == r_iow && !r && a[2:0] == 3'd1) m_snd = d[0];
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] q);
        bus_cycle(a, 1'b1, 1'b1, 8'h00, q);
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] unused_q;
        bus_cycle(a, 1'b0, 1'b1, d, unused_q);
    endtask

    task automatic bus_idle();
        logic [7:0] unused_q;
        bus_cycle(16'h0000, 1'b1, 1'b0, 8'h00, unused_q);   // vma low
    endtask

    task automatic shuffle_inputs();
        logic [31:0] r;
        r            = $random(seed);
        rom_data     = r[7:0];
        vram_dout    = r[15:8];
        obj_dout     = r[23:16];
        dipsw_a      = r[31:24];
        r            = $random(seed);
        dipsw_b      = r[7:0];
        dipsw_c      = r[10:8];
        start_button = r[12:11];
        coin_input   = r[14:13];
        service      = r[15];
        joystick1    = r[22:16];
        joystick2    = r[29:23];
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        @(negedge clk);                      // compare queue drained by now
        $display("test %0d %s: %0d errors", num, name, n_errors - err_start);
    endtask

    initial begin : watchdog
        #(timeout_ns);
        $display("watchdog: bus cycles not done after %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [15:0] a;
        logic [7:0]  q;
        tb_region_t  rg;
        int          err0;
        rst       = 1'b1;
        addr      = 16'h0000;
        rnw       = 1'b1;
        vma       = 1'b0;
        cpu_dout  = 8'h00;
        lvbl      = 1'b1;
        dip_pause = 1'b1;
        shuffle_inputs();
        {m_flip, m_snd, m_frame, m_intst} = 4'b0000;   // reset state
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // 1: decode, random vma and rnw, every fourth address in 1000-1FFF
        err0 = n_errors;
        for (int i = 0; i < n_decode; i++) begin
            r = $random(seed);
            a = (i % 4 == 0) ? {4'h1, r[11:0]} : r[15:0];
            bus_cycle(a, r[16], r[17] | r[18], r[31:24], q);
            rg = ref_region(a, r[16], r[17] | r[18]);
            expect_val("rom_cs/vram_cs/objram_cs/snd_data_cs",
                       {4'd0, rg == r_rom, rg == r_vram, rg == r_obj, rg == r_snd},
                       {4'd0, rom_cs, vram_cs, objram_cs, snd_data_cs});
        end
        report_test(1, "decode", err0);

        // 2: read mux through each region
        err0 = n_errors;
        for (int i = 0; i < n_mux; i++) begin
            shuffle_inputs();
            r = $random(seed);
            case (i % 10)
                0: begin
                    a     = r[15:0];
                    a[14] = a[14] | !a[15];  // keep it at 4000 or above
                end
                1: a = {4'h2, r[11:0]};       // vram
                2: a = {6'd4, r[9:0]};        // obj RAM
                4: a = {9'd44, r[6:0]};       // in5
                5: a = {7'd10, r[8:0]};       // intst, iow, snd, sel 3
                6: a = {8'h17, r[7:0]};       // sel 6 and 7, open
                7: a = {4'h0, r[11:0]};       // 0000-0FFF, open
                8: a = {5'd3, r[10:0]};       // 1800-1FFF, open
                default: a = {9'd45, r[6:0]}; // ior, all four cabinet words
            endcase
            bus_read(a, q);
            expect_val("cpu_din", ref_din(a), q);
        end
        report_test(2, "read mux", err0);

        // 3: work RAM against the shadow copy
        err0 = n_errors;
        for (int i = 0; i < n_ram; i++) begin
            r = $random(seed);
            a = {4'h3, r[11:0]};
            ram_addr_q.push_back(a);
            bus_write(a, r[23:16]);
        end
        foreach (ram_addr_q[i]) begin
            bus_read(ram_addr_q[i], q);
            expect_val("cpu_din", ref_din(ram_addr_q[i]), q);
        end
        report_test(3, "work ram", err0);

        // 4: every latch index twice, then intst accesses
        err0 = n_errors;
        latch_checks = 1'b1;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            bus_write({13'h0290, i[2:0]}, r[7:0]);   // 1480-1487
            bus_idle();
        end
        bus_read(16'h1400, q);
        bus_idle();
        bus_read(16'h1400, q);                // second separate access
        bus_idle();
        bus_read(16'h1400, q);
        bus_read(16'h1404, q);                // same access held, no toggle
        bus_idle();
        bus_idle();
        latch_checks = 1'b0;
        report_test(4, "latch and frame", err0);

        // 5: vblank interrupt
        err0 = n_errors;
        bus_write(16'h1487, 8'h01);           // irq_clrn high
        bus_idle();
        expect_val("irq_n", 8'h01, {7'd0, irq_n});
        lvbl = 1'b0;                          // vblank starts
        bus_idle();
        expect_val("irq_n", 8'h00, {7'd0, irq_n});
        bus_write(16'h1487, 8'h00);           // acknowledge
        bus_idle();
        expect_val("irq_n", 8'h01, {7'd0, irq_n});
        lvbl = 1'b1;
        bus_write(16'h1487, 8'h01);
        dip_pause = 1'b0;                     // paused, vblank masked
        bus_idle();
        lvbl = 1'b0;
        bus_idle();
        expect_val("irq_n", 8'h01, {7'd0, irq_n});
        report_test(5, "interrupt", err0);

        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* roadf_board.f */
verilog/roadf_pkg.sv
verilog/roadf_cen.sv
verilog/roadf_irq_ff.sv
verilog/roadf_work_ram.sv
verilog/roadf_main.sv
verilog/roadf_board.sv
bench/roadf_board_assertions.sv
bench/roadf_board_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the roadf_board testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module roadf_board_tb \
    -f roadf_board.f --Mdir obj_dir -o roadf_board_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/roadf_board_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
